// ==== all.f ====
verilog/cpu_pkg.sv
verilog/wb_bus_if.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/pipeline_cpu.sv
test/tb_memory.sv
test/tb_pipeline_cpu.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_pipeline_cpu -f all.f
	./obj_dir/Vtb_pipeline_cpu | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/tb_pipeline_cpu.sv ====
`timescale 1ns/1ps

module tb_pipeline_cpu;

	localparam int NUM_ENTRIES = 16;
	localparam int MAX_PROG = 8;
	localparam int CYCLES_PER_ENTRY = 40;
	localparam int CYCLE_LIMIT = CYCLES_PER_ENTRY * NUM_ENTRIES;
	localparam int HOLD_CYCLES = 3;
	localparam int FIRST_RANDOM = 11;

	logic clk = 1'b0;
	logic reset_n;
	cpu_pkg::word_t data1;
	cpu_pkg::word_t data2_in;
	logic read_m1;
	logic read_m2;
	logic write_m2;
	cpu_pkg::word_t address1;
	cpu_pkg::word_t address2;
	cpu_pkg::word_t data2_out;
	cpu_pkg::word_t num_inst;
	cpu_pkg::word_t output_port;
	logic is_halted;

	// program load port of the memory model
	logic mem_clear;
	logic mem_load;
	logic [7:0] load_addr;
	cpu_pkg::word_t load_data;

	// program table with expected results
	cpu_pkg::word_t prog [NUM_ENTRIES][MAX_PROG];
	int prog_len [NUM_ENTRIES];
	cpu_pkg::word_t exp_port [NUM_ENTRIES];
	cpu_pkg::word_t exp_inst [NUM_ENTRIES];
	int exp_reads [NUM_ENTRIES];
	int exp_writes [NUM_ENTRIES];

	// strobe cycles of the entry in flight
	int fetches = 0;
	int mem_reads = 0;
	int mem_writes = 0;

	int errors = 0;
	int checks = 0;
	int cycles = 0;

	always #2 clk = ~clk;

	pipeline_cpu u_pipeline_cpu (
		.clk(clk),
		.reset_n(reset_n),
		.data1_i(data1),
		.data2_i(data2_in),
		.read_m1_o(read_m1),
		.address1_o(address1),
		.read_m2_o(read_m2),
		.write_m2_o(write_m2),
		.address2_o(address2),
		.data2_o(data2_out),
		.num_inst_o(num_inst),
		.output_port_o(output_port),
		.is_halted_o(is_halted)
	);

	tb_memory u_memory (
		.clk(clk),
		.address1_i(address1),
		.data1_o(data1),
		.read_m2_i(read_m2),
		.write_m2_i(write_m2),
		.address2_i(address2),
		.wdata2_i(data2_out),
		.rdata2_o(data2_in),
		.clear_i(mem_clear),
		.load_i(mem_load),
		.load_addr_i(load_addr),
		.load_data_i(load_data)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the CPU never reached HLT", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// memory strobes sampled mid-cycle
	always @(negedge clk) begin
		if (read_m1 === 1'b1) begin
			fetches++;
		end
		if (read_m2 === 1'b1) begin
			mem_reads++;
		end
		if (write_m2 === 1'b1) begin
			mem_writes++;
		end
	end

	function automatic cpu_pkg::word_t rtype_word(input cpu_pkg::func_t func,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
		input cpu_pkg::reg_addr_t rd);
		return {cpu_pkg::OP_RTYPE, rs, rt, rd, func};
	endfunction

	function automatic cpu_pkg::word_t itype_word(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rs, input cpu_pkg::reg_addr_t rt,
		input cpu_pkg::imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic append_instr(input int idx, input cpu_pkg::word_t instr);
		prog[idx][prog_len[idx]] = instr;
		prog_len[idx] = prog_len[idx] + 1;
		// each load reads and each store writes the data memory once
		if (instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB] == cpu_pkg::OP_LWD) begin
			exp_reads[idx] = exp_reads[idx] + 1;
		end
		if (instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB] == cpu_pkg::OP_SWD) begin
			exp_writes[idx] = exp_writes[idx] + 1;
		end
	endtask

	task automatic close_case(input int idx, input cpu_pkg::word_t port);
		append_instr(idx, rtype_word(cpu_pkg::FUNC_HLT, 2'd0, 2'd0, 2'd0));
		exp_port[idx] = port;
		// straight-line code retires every word up to and including HLT
		exp_inst[idx] = cpu_pkg::word_t'(prog_len[idx]);
	endtask

	// r1 = 0x1234 and r2 = 0x01f0 with the result in r3
	task automatic rtype_case(input int idx, input cpu_pkg::func_t func,
		input cpu_pkg::word_t port);
		append_instr(idx, itype_word(cpu_pkg::OP_LHI, 2'd0, 2'd1, 8'h12));
		append_instr(idx, itype_word(cpu_pkg::OP_ORI, 2'd1, 2'd1, 8'h34));
		append_instr(idx, itype_word(cpu_pkg::OP_LHI, 2'd0, 2'd2, 8'h01));
		append_instr(idx, itype_word(cpu_pkg::OP_ORI, 2'd2, 2'd2, 8'hf0));
		append_instr(idx, rtype_word(func, 2'd1, 2'd2, 2'd3));
		append_instr(idx, rtype_word(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0));
		close_case(idx, port);
	endtask

	// r1 from two random bytes and r2 a random signed offset away from it
	task automatic random_case(input int idx);
		logic [31:0] bits;
		cpu_pkg::word_t a;
		cpu_pkg::word_t b;
		cpu_pkg::word_t c;
		cpu_pkg::word_t d;
		cpu_pkg::func_t op1;
		cpu_pkg::func_t op2;
		bits = $urandom;
		a = bits[15:0];
		b = a + {{8{bits[23]}}, bits[23:16]};
		op1 = bits[24] ? cpu_pkg::FUNC_SUB : cpu_pkg::FUNC_ADD;
		op2 = bits[25] ? cpu_pkg::FUNC_SUB : cpu_pkg::FUNC_ADD;
		c = bits[24] ? a - b : a + b;
		d = bits[25] ? c - a : c + a;
		append_instr(idx, itype_word(cpu_pkg::OP_LHI, 2'd0, 2'd1, bits[15:8]));
		append_instr(idx, itype_word(cpu_pkg::OP_ORI, 2'd1, 2'd1, bits[7:0]));
		append_instr(idx, itype_word(cpu_pkg::OP_ADI, 2'd1, 2'd2, bits[23:16]));
		append_instr(idx, rtype_word(op1, 2'd1, 2'd2, 2'd3));
		append_instr(idx, rtype_word(op2, 2'd3, 2'd1, 2'd0));
		append_instr(idx, rtype_word(cpu_pkg::FUNC_WWD, 2'd0, 2'd0, 2'd0));
		close_case(idx, d);
	endtask

	task automatic build_table();
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			prog_len[e] = 0;
			exp_reads[e] = 0;
			exp_writes[e] = 0;
		end
		rtype_case(0, cpu_pkg::FUNC_ADD, 16'h1424);
		rtype_case(1, cpu_pkg::FUNC_SUB, 16'h1044);
		rtype_case(2, cpu_pkg::FUNC_AND, 16'h0030);
		rtype_case(3, cpu_pkg::FUNC_ORR, 16'h13f4);
		rtype_case(4, cpu_pkg::FUNC_NOT, 16'hedcb);

		// 0xfffe + 0x0080 + 0xa500
		append_instr(5, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'hfe));
		append_instr(5, itype_word(cpu_pkg::OP_ORI, 2'd0, 2'd2, 8'h80));
		append_instr(5, itype_word(cpu_pkg::OP_LHI, 2'd0, 2'd3, 8'ha5));
		append_instr(5, rtype_word(cpu_pkg::FUNC_ADD, 2'd1, 2'd2, 2'd0));
		append_instr(5, rtype_word(cpu_pkg::FUNC_ADD, 2'd0, 2'd3, 2'd0));
		append_instr(5, rtype_word(cpu_pkg::FUNC_WWD, 2'd0, 2'd0, 2'd0));
		close_case(5, 16'ha57e);

		// back to back chain where r3 ends as 23 + 8 - 15
		append_instr(6, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h03));
		append_instr(6, itype_word(cpu_pkg::OP_ADI, 2'd1, 2'd1, 8'h05));
		append_instr(6, itype_word(cpu_pkg::OP_ADI, 2'd1, 2'd2, 8'h07));
		append_instr(6, rtype_word(cpu_pkg::FUNC_ADD, 2'd1, 2'd2, 2'd3));
		append_instr(6, rtype_word(cpu_pkg::FUNC_ADD, 2'd3, 2'd1, 2'd3));
		append_instr(6, rtype_word(cpu_pkg::FUNC_SUB, 2'd3, 2'd2, 2'd3));
		append_instr(6, rtype_word(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0));
		close_case(6, 16'h0010);

		// producers one instruction apart
		append_instr(7, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h11));
		append_instr(7, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h22));
		append_instr(7, rtype_word(cpu_pkg::FUNC_ADD, 2'd1, 2'd2, 2'd3));
		append_instr(7, itype_word(cpu_pkg::OP_ORI, 2'd0, 2'd0, 8'h40));
		append_instr(7, rtype_word(cpu_pkg::FUNC_ADD, 2'd3, 2'd0, 2'd1));
		append_instr(7, rtype_word(cpu_pkg::FUNC_ADD, 2'd2, 2'd2, 2'd2));
		append_instr(7, rtype_word(cpu_pkg::FUNC_WWD, 2'd1, 2'd0, 2'd0));
		close_case(7, 16'h0073);

		// store then load at 0x14 with WWD right behind the load
		append_instr(8, itype_word(cpu_pkg::OP_LHI, 2'd0, 2'd1, 8'hbe));
		append_instr(8, itype_word(cpu_pkg::OP_ORI, 2'd1, 2'd1, 8'hef));
		append_instr(8, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h10));
		append_instr(8, itype_word(cpu_pkg::OP_SWD, 2'd2, 2'd1, 8'h04));
		append_instr(8, itype_word(cpu_pkg::OP_LWD, 2'd2, 2'd3, 8'h04));
		append_instr(8, rtype_word(cpu_pkg::FUNC_WWD, 2'd3, 2'd0, 2'd0));
		close_case(8, 16'hbeef);

		// negative offset to 0x1f and the loaded value used as rt at once
		append_instr(9, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd1, 8'h20));
		append_instr(9, itype_word(cpu_pkg::OP_ADI, 2'd0, 2'd2, 8'h55));
		append_instr(9, itype_word(cpu_pkg::OP_SWD, 2'd1, 2'd2, 8'hff));
		append_instr(9, itype_word(cpu_pkg::OP_LWD, 2'd1, 2'd3, 8'hff));
		append_instr(9, rtype_word(cpu_pkg::FUNC_ADD, 2'd1, 2'd3, 2'd0));
		append_instr(9, rtype_word(cpu_pkg::FUNC_WWD, 2'd0, 2'd0, 2'd0));
		close_case(9, 16'h0075);

		// a lone HLT leaves the port cleared
		close_case(10, 16'h0000);

		for (int e = FIRST_RANDOM; e < NUM_ENTRIES; e++) begin
			random_case(e);
		end
	endtask

	task automatic check_word(input int idx, input string name,
		input cpu_pkg::word_t actual, input cpu_pkg::word_t expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch at %0t, entry %0d, %s is %h, expected %h",
				$time, idx, name, actual, expected);
		end
	endtask

	task automatic load_program(input int idx);
		@(negedge clk);
		mem_clear = 1'b1;
		@(negedge clk);
		mem_clear = 1'b0;
		for (int i = 0; i < prog_len[idx]; i++) begin
			mem_load = 1'b1;
			load_addr = 8'(i);
			load_data = prog[idx][i];
			@(negedge clk);
		end
		mem_load = 1'b0;
	endtask

	task automatic pulse_reset();
		reset_n = 1'b0;
		repeat (2) @(negedge clk);
		reset_n = 1'b1;
	endtask

	task automatic check_after_reset(input int idx);
		check_word(idx, "num_inst_o", num_inst, 16'd0);
		check_word(idx, "output_port_o", output_port, 16'd0);
		check_word(idx, "is_halted_o", cpu_pkg::word_t'(is_halted), 16'd0);
		check_word(idx, "read_m1_o", cpu_pkg::word_t'(read_m1), 16'd0);
	endtask

	task automatic wait_halt();
		while (is_halted !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	// halted CPU keeps its flag and fetches nothing
	task automatic check_halt_hold(input int idx);
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			check_word(idx, "is_halted_o", cpu_pkg::word_t'(is_halted), 16'd1);
			check_word(idx, "read_m1_o", cpu_pkg::word_t'(read_m1), 16'd0);
			check_word(idx, "num_inst_o", num_inst, exp_inst[idx])
				;
		end
	endtask

	// every word is fetched once and each memory access strobes once
	task automatic check_strobe_counts(input int idx);
		check_word(idx, "read_m1_o high cycles", cpu_pkg::word_t'(fetches),
			cpu_pkg::word_t'(prog_len[idx]));
		check_word(idx, "read_m2_o high cycles", cpu_pkg::word_t'(mem_reads),
			cpu_pkg::word_t'(exp_reads[idx]));
		check_word(idx, "write_m2_o high cycles", cpu_pkg::word_t'(mem_writes),
			cpu_pkg::word_t'(exp_writes[idx]));
	endtask

	initial begin
		reset_n = 1'b0;
		mem_clear = 1'b0;
		mem_load = 1'b0;
		load_addr = '0;
		load_data = '0;
		void'($urandom(32'ha8fa));
		build_table();
		for (int e = 0; e < NUM_ENTRIES; e++) begin
			load_program(e);
			fetches = 0;
			mem_reads = 0;
			mem_writes = 0;
			pulse_reset();
			check_after_reset(e);
			wait_halt();
			check_word(e, "output_port_o", output_port, exp_port[e]);
			check_word(e, "num_inst_o", num_inst, exp_inst[e]);
			check_halt_hold(e);
			check_strobe_counts(e);
		end
		$display("%0d entries, %0d checks, %0d errors", NUM_ENTRIES, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== test/tb_memory.sv ====
`timescale 1ns/1ps

// instruction and data memory behind the CPU ports, with a load port for programs
module tb_memory (
	input logic clk,
	input cpu_pkg::word_t address1_i,
	output cpu_pkg::word_t data1_o,
	input logic read_m2_i,
	input logic write_m2_i,
	input cpu_pkg::word_t address2_i,
	input cpu_pkg::word_t wdata2_i,
	output cpu_pkg::word_t rdata2_o,
	input logic clear_i,
	input logic load_i,
	input logic [7:0] load_addr_i,
	input cpu_pkg::word_t load_data_i
);

	localparam int DEPTH = 256;

	cpu_pkg::word_t imem [DEPTH];
	cpu_pkg::word_t dmem [DEPTH];

	// both memories answer in the same cycle
	assign data1_o = imem[address1_i[7:0]];
	assign rdata2_o = read_m2_i ? dmem[address2_i[7:0]] : '0;

	always @(posedge clk) begin
		if (clear_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				// every word differs, so a stray access shows up
				imem[i] = cpu_pkg::word_t'(i);
				dmem[i] = {i[7:0], ~i[7:0]};
			end
		end else if (load_i) begin
			imem[load_addr_i] = load_data_i;
		end
		if (write_m2_i) begin
			dmem[address2_i[7:0]] = wdata2_i;
		end
	end

endmodule

// ==== verilog/pipeline_cpu.sv ====
`timescale 1ns/1ps

module pipeline_cpu (
	input logic clk,
	input logic reset_n,
	input cpu_pkg::word_t data1_i,
	input cpu_pkg::word_t data2_i,
	output logic read_m1_o,
	output cpu_pkg::word_t address1_o,
	output logic read_m2_o,
	output logic write_m2_o,
	output cpu_pkg::word_t address2_o,
	output cpu_pkg::word_t data2_o,
	output cpu_pkg::word_t num_inst_o,
	output cpu_pkg::word_t output_port_o,
	output logic is_halted_o
);

	typedef enum logic [1:0] {
		F_IDLE,
		F_RUN,
		F_HALT
	} fetch_state_e;

	fetch_state_e fetch_state;
	cpu_pkg::word_t pc;

	// IF/ID
	cpu_pkg::word_t if_id_instr;
	logic if_id_valid;

	// decode outputs
	cpu_pkg::reg_addr_t dec_rs, dec_rt, dec_dest;
	cpu_pkg::word_t dec_imm, rs_data, rt_data;
	cpu_pkg::ctrl_t dec_ctrl;
	logic id_halt, stall;

	// ID/EX
	cpu_pkg::ctrl_t idex_ctrl;
	cpu_pkg::word_t idex_rs_data, idex_rt_data, idex_imm;
	cpu_pkg::reg_addr_t idex_dest;

	// execute
	cpu_pkg::fwd_sel_t fwd_a, fwd_b;
	cpu_pkg::word_t alu_result, alu_store;

	// EX/MEM
	cpu_pkg::ctrl_t exmem_ctrl;
	cpu_pkg::word_t exmem_result, exmem_store;
	cpu_pkg::reg_addr_t exmem_dest;

	// MEM/WB
	cpu_pkg::ctrl_t memwb_ctrl;
	cpu_pkg::word_t memwb_data;
	cpu_pkg::reg_addr_t memwb_dest;

	wb_bus_if wb_bus ();

	assign id_halt = if_id_valid && dec_ctrl.halt;
	// no fetch behind a decoded HLT
	assign read_m1_o = (fetch_state == F_RUN) && !stall && !id_halt;
	assign address1_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			fetch_state <= F_IDLE;
		end else begin
			case (fetch_state)
				F_IDLE: fetch_state <= F_RUN;
				F_RUN: if (id_halt) fetch_state <= F_HALT;
				default: fetch_state <= F_HALT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			if_id_valid <= 1'b0;
		end else if (read_m1_o) begin
			pc <= pc + cpu_pkg::word_t'(1);
			if_id_valid <= 1'b1;
		end else if (!stall) begin
			if_id_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (read_m1_o) begin
			if_id_instr <= data1_i;
		end
	end

	decode_unit u_decode_unit (
		.instr_i(if_id_instr),
		.rs_o(dec_rs),
		.rt_o(dec_rt),
		.dest_o(dec_dest),
		.imm_o(dec_imm),
		.ctrl_o(dec_ctrl)
	);

	register_file u_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.rs_i(dec_rs),
		.rt_i(dec_rt),
		.rs_data_o(rs_data),
		.rt_data_o(rt_data),
		.wb(wb_bus)
	);

	hazard_unit u_hazard_unit (
		.clk(clk),
		.reset_n(reset_n),
		.id_rs_i(dec_rs),
		.id_rt_i(dec_rt),
		.ex_dest_i(idex_dest),
		.mem_dest_i(exmem_dest),
		.ex_mem_read_i(idex_ctrl.mem_read),
		.ex_valid_reg_write_i(idex_ctrl.valid && idex_ctrl.reg_write),
		.mem_reg_write_i(exmem_ctrl.valid && exmem_ctrl.reg_write),
		.wb(wb_bus),
		.stall_o(stall),
		.fwd_a_o(fwd_a),
		.fwd_b_o(fwd_b)
	);

	// bubble on stall or empty decode slot
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			idex_ctrl <= cpu_pkg::CTRL_BUBBLE;
		end else if (if_id_valid && !stall) begin
			idex_ctrl <= dec_ctrl;
		end else begin
			idex_ctrl <= cpu_pkg::CTRL_BUBBLE;
		end
	end

	always_ff @(posedge clk) begin
		idex_rs_data <= rs_data;
		idex_rt_data <= rt_data;
		idex_imm <= dec_imm;
		idex_dest <= dec_dest;
	end

	alu u_alu (
		.alu_op_i(idex_ctrl.alu_op),
		.fwd_a_i(fwd_a),
		.fwd_b_i(fwd_b),
		.rs_data_i(idex_rs_data),
		.rt_data_i(idex_rt_data),
		.exmem_data_i(exmem_result),
		.imm_i(idex_imm),
		.alu_src_imm_i(idex_ctrl.alu_src_imm),
		.wb(wb_bus),
		.result_o(alu_result),
		.store_data_o(alu_store)
	);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			exmem_ctrl <= cpu_pkg::CTRL_BUBBLE;
			memwb_ctrl <= cpu_pkg::CTRL_BUBBLE;
		end else begin
			exmem_ctrl <= idex_ctrl;
			memwb_ctrl <= exmem_ctrl;
		end
	end

	always_ff @(posedge clk) begin
		exmem_result <= alu_result;
		exmem_store <= alu_store;
		exmem_dest <= idex_dest;
		memwb_data <= exmem_ctrl.mem_read ? data2_i : exmem_result;
		memwb_dest <= exmem_dest;
	end

	// data memory answers in the same cycle
	assign read_m2_o = exmem_ctrl.mem_read;
	assign write_m2_o = exmem_ctrl.mem_write;
	assign address2_o = exmem_result;
	assign data2_o = exmem_store;

	assign wb_bus.reg_write = memwb_ctrl.valid && memwb_ctrl.reg_write;
	assign wb_bus.dest = memwb_dest;
	assign wb_bus.data = memwb_data;
	assign wb_bus.wwd = memwb_ctrl.valid && memwb_ctrl.wwd;
	assign wb_bus.halt = memwb_ctrl.valid && memwb_ctrl.halt;

	// retirement side effects
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst_o <= '0;
			output_port_o <= '0;
			is_halted_o <= 1'b0;
		end else begin
			if (memwb_ctrl.valid) begin
				num_inst_o <= num_inst_o + cpu_pkg::word_t'(1);
			end
			if (wb_bus.wwd) begin
				output_port_o <= wb_bus.data;
			end
			if (wb_bus.halt) begin
				is_halted_o <= 1'b1;
			end
		end
	end

	a_mem_strobes: assert property (
		@(posedge clk) disable iff (!reset_n) !(read_m2_o && write_m2_o)
	) else $error("data memory read and write strobes both high");

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input logic clk,
	input logic reset_n,
	input cpu_pkg::reg_addr_t id_rs_i,
	input cpu_pkg::reg_addr_t id_rt_i,
	input cpu_pkg::reg_addr_t ex_dest_i,
	input cpu_pkg::reg_addr_t mem_dest_i,
	input logic ex_mem_read_i,
	input logic ex_valid_reg_write_i,
	input logic mem_reg_write_i,
	wb_bus_if.snoop wb,
	output logic stall_o,
	output cpu_pkg::fwd_sel_t fwd_a_o,
	output cpu_pkg::fwd_sel_t fwd_b_o
);

	// source indices of the instruction now in execute
	cpu_pkg::reg_addr_t ex_rs;
	cpu_pkg::reg_addr_t ex_rt;

	// both fields compared, even when an opcode ignores rt
	assign stall_o = ex_mem_read_i && ex_valid_reg_write_i &&
		(ex_dest_i == id_rs_i || ex_dest_i == id_rt_i);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_rs <= '0;
			ex_rt <= '0;
		end else begin
			ex_rs <= id_rs_i;
			ex_rt <= id_rt_i;
		end
	end

	// newest producer wins
	function automatic cpu_pkg::fwd_sel_t pick_source(cpu_pkg::reg_addr_t src);
		if (mem_reg_write_i && mem_dest_i == src) begin
			return cpu_pkg::FWD_EXMEM;
		end else if (wb.reg_write && wb.dest == src) begin
			return cpu_pkg::FWD_WB;
		end
		return cpu_pkg::FWD_REG;
	endfunction

	always_comb begin
		fwd_a_o = pick_source(ex_rs);
		fwd_b_o = pick_source(ex_rt);
	end

	// a stall always pushes a bubble into ID/EX
	a_single_stall: assert property (
		@(posedge clk) disable iff (!reset_n) stall_o |=> !stall_o
	) else $error("load-use stall held for two cycles");

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpu_pkg::alu_op_e alu_op_i,
	input cpu_pkg::fwd_sel_t fwd_a_i,
	input cpu_pkg::fwd_sel_t fwd_b_i,
	input cpu_pkg::word_t rs_data_i,
	input cpu_pkg::word_t rt_data_i,
	input cpu_pkg::word_t exmem_data_i,
	input cpu_pkg::word_t imm_i,
	input logic alu_src_imm_i,
	wb_bus_if.snoop wb,
	output cpu_pkg::word_t result_o,
	output cpu_pkg::word_t store_data_o
);

	cpu_pkg::word_t op_a;
	cpu_pkg::word_t op_b;
	cpu_pkg::word_t rt_fwd;

	function automatic cpu_pkg::word_t select_operand(
		cpu_pkg::fwd_sel_t sel,
		cpu_pkg::word_t reg_val,
		cpu_pkg::word_t exmem_val,
		cpu_pkg::word_t wb_val
	);
		case (sel)
			cpu_pkg::FWD_EXMEM: return exmem_val;
			cpu_pkg::FWD_WB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	always_comb begin
		op_a = select_operand(fwd_a_i, rs_data_i, exmem_data_i, wb.data);
		rt_fwd = select_operand(fwd_b_i, rt_data_i, exmem_data_i, wb.data);
		op_b = alu_src_imm_i ? imm_i : rt_fwd;
		case (alu_op_i)
			cpu_pkg::ALU_ADD: result_o = op_a + op_b;
			cpu_pkg::ALU_SUB: result_o = op_a - op_b;
			cpu_pkg::ALU_AND: result_o = op_a & op_b;
			cpu_pkg::ALU_OR: result_o = op_a | op_b;
			cpu_pkg::ALU_NOT: result_o = ~op_a;
			cpu_pkg::ALU_LHI: result_o = op_b;
			default: result_o = '0;
		endcase
	end

	// SWD stores the forwarded rt, not the immediate
	assign store_data_o = rt_fwd;

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
	input cpu_pkg::word_t instr_i,
	output cpu_pkg::reg_addr_t rs_o,
	output cpu_pkg::reg_addr_t rt_o,
	output cpu_pkg::reg_addr_t dest_o,
	output cpu_pkg::word_t imm_o,
	output cpu_pkg::ctrl_t ctrl_o
);

	cpu_pkg::opcode_t opcode;
	cpu_pkg::func_t func;
	cpu_pkg::imm_t imm;
	cpu_pkg::reg_addr_t rd;

	assign opcode = instr_i[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB];
	assign func = instr_i[cpu_pkg::FUNC_MSB:cpu_pkg::FUNC_LSB];
	assign imm = instr_i[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];
	assign rs_o = instr_i[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
	assign rt_o = instr_i[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
	assign rd = instr_i[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];

	always_comb begin
		// valid no-op unless an encoding below matches
		ctrl_o = cpu_pkg::CTRL_BUBBLE;
		ctrl_o.valid = 1'b1;
		ctrl_o.alu_op = cpu_pkg::ALU_ADD;
		imm_o = {{(cpu_pkg::WORD_SIZE - 8){imm[7]}}, imm};
		dest_o = rt_o;

		case (opcode)
			cpu_pkg::OP_RTYPE: begin
				dest_o = rd;
				case (func)
					cpu_pkg::FUNC_ADD: begin
						ctrl_o.reg_write = 1'b1;
						ctrl_o.alu_op = cpu_pkg::ALU_ADD;
					end
					cpu_pkg::FUNC_SUB: begin
						ctrl_o.reg_write = 1'b1;
						ctrl_o.alu_op = cpu_pkg::ALU_SUB;
					end
					cpu_pkg::FUNC_AND: begin
						ctrl_o.reg_write = 1'b1;
						ctrl_o.alu_op = cpu_pkg::ALU_AND;
					end
					cpu_pkg::FUNC_ORR: begin
						ctrl_o.reg_write = 1'b1;
						ctrl_o.alu_op = cpu_pkg::ALU_OR;
					end
					cpu_pkg::FUNC_NOT: begin
						ctrl_o.reg_write = 1'b1;
						ctrl_o.alu_op = cpu_pkg::ALU_NOT;
					end
					cpu_pkg::FUNC_WWD: begin
						// rs + 0 carries rs down to write-back
						ctrl_o.wwd = 1'b1;
						ctrl_o.alu_src_imm = 1'b1;
						imm_o = '0;
					end
					cpu_pkg::FUNC_HLT: begin
						ctrl_o.halt = 1'b1;
					end
					default: begin
					end
				endcase
			end
			cpu_pkg::OP_ADI: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
			end
			cpu_pkg::OP_ORI: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.alu_op = cpu_pkg::ALU_OR;
				imm_o = {{(cpu_pkg::WORD_SIZE - 8){1'b0}}, imm};
			end
			cpu_pkg::OP_LHI: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
				ctrl_o.alu_op = cpu_pkg::ALU_LHI;
				imm_o = {imm, 8'h00};
			end
			cpu_pkg::OP_LWD: begin
				ctrl_o.reg_write = 1'b1;
				ctrl_o.mem_read = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
			end
			cpu_pkg::OP_SWD: begin
				ctrl_o.mem_write = 1'b1;
				ctrl_o.alu_src_imm = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic reset_n,
	input cpu_pkg::reg_addr_t rs_i,
	input cpu_pkg::reg_addr_t rt_i,
	output cpu_pkg::word_t rs_data_o,
	output cpu_pkg::word_t rt_data_o,
	wb_bus_if.write wb
);

	cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write) begin
			regs[wb.dest] <= wb.data;
		end
	end

	// write-through so decode sees the value retiring this cycle
	always_comb begin
		if (wb.reg_write && wb.dest == rs_i) begin
			rs_data_o = wb.data;
		end else begin
			rs_data_o = regs[rs_i];
		end
		if (wb.reg_write && wb.dest == rt_i) begin
			rt_data_o = wb.data;
		end else begin
			rt_data_o = regs[rt_i];
		end
	end

	// MEM/WB controls are cleared by the reset edge
	a_no_write_after_reset: assert property (
		@(posedge clk) !reset_n |=> !wb.reg_write
	) else $error("register write reported right after reset");

endmodule

// ==== verilog/wb_bus_if.sv ====
`timescale 1ns/1ps

// write-back result leaving the MEM/WB register
interface wb_bus_if;

	logic reg_write;
	cpu_pkg::reg_addr_t dest;
	cpu_pkg::word_t data;
	logic wwd;
	logic halt;

	modport source (
		output reg_write, dest, data, wwd, halt
	);

	modport write (
		input reg_write, dest, data
	);

	// forwarding side only needs the register result
	modport snoop (
		input reg_write, dest, data
	);

endinterface

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	localparam int WORD_SIZE = 16;
	localparam int NUM_REGS = 4;

	typedef logic [WORD_SIZE-1:0] word_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [7:0] imm_t;
	typedef logic [1:0] fwd_sel_t;

	// instruction field positions
	localparam int OPCODE_MSB = 15;
	localparam int OPCODE_LSB = 12;
	localparam int RS_MSB = 11;
	localparam int RS_LSB = 10;
	localparam int RT_MSB = 9;
	localparam int RT_LSB = 8;
	localparam int RD_MSB = 7;
	localparam int RD_LSB = 6;
	localparam int FUNC_MSB = 5;
	localparam int FUNC_LSB = 0;
	localparam int IMM_MSB = 7;
	localparam int IMM_LSB = 0;

	// opcodes
	localparam opcode_t OP_RTYPE = 4'd15;
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_ORI = 4'd5;
	localparam opcode_t OP_LHI = 4'd6;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;

	// function codes of R-type
	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_WWD = 6'd28;
	localparam func_t FUNC_HLT = 6'd29;

	// operand source in execute
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_EXMEM = 2'd1;
	localparam fwd_sel_t FWD_WB = 2'd2;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_LHI
	} alu_op_e;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic alu_src_imm;
		alu_op_e alu_op;
		logic wwd;
		logic halt;
		logic valid;
	} ctrl_t;

	localparam ctrl_t CTRL_BUBBLE = '0;

endpackage
